/* include/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ALU operation codes as carried in the decoded instruction.
`define ALU_OPC_ADD     5'h00
`define ALU_OPC_ADDC    5'h01
`define ALU_OPC_SUB     5'h02
`define ALU_OPC_SUBC    5'h03
`define ALU_OPC_LSL     5'h04
`define ALU_OPC_LSR     5'h05
`define ALU_OPC_AND     5'h06
`define ALU_OPC_XOR     5'h07
`define ALU_OPC_BIC     5'h08
`define ALU_OPC_BST     5'h09
`define ALU_OPC_OR      5'h0a
`define ALU_OPC_COPYB   5'h0b
`define ALU_OPC_CMP     5'h0c
`define ALU_OPC_MOVHI   5'h0d
`define ALU_OPC_ASR     5'h0e
`define ALU_OPC_COPYA   5'h0f
`define ALU_OPC_GCR     5'h10
`define ALU_OPC_SWI     5'h11
`define ALU_OPC_RFE     5'h12

// Instruction classes.
`define CLASS_ARITH     2'b00
`define CLASS_BRANCH    2'b01
`define CLASS_LDR_STR   2'b10
`define CLASS_MISC      2'b11

// Branch conditions. Code zero is never taken.
`define BR_NEVER        3'b000
`define BR_NE           3'b001
`define BR_EQ           3'b010
`define BR_NC           3'b011
`define BR_C            3'b100
`define BR_GT           3'b101
`define BR_LT           3'b110
`define BR_ALWAYS       3'b111

// Control register indices.
`define CR_VECTOR       3'h0
`define CR_PSR          3'h1
`define CR_SAVED_PSR    3'h2
`define CR_FAULT        3'h3
`define CR_DATA_FAULT   3'h4

`endif

/* rtl/exec_pkg.sv */
package exec_pkg;

	// Processor status word.
	// Software sees the whole word through GCR and control register
	// writes, while the flag logic works on the named bits.
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [27:0] reserved;
			logic        n;
			logic        o;
			logic        c;
			logic        z;
		} flags;
	} psr_word_u;

endpackage

/* rtl/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_alu
	import exec_pkg::*;
(
	input  logic [31:0] i_ra,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_imm32,
	input  logic [31:0] i_pc_plus_4,
	input  logic [4:0]  i_alu_opc,
	input  logic        i_alu_op1_ra,
	input  logic        i_alu_op1_rb,
	input  logic        i_alu_op2_rb,
	input  logic        i_c_flag,
	input  logic [2:0]  i_cr_sel,
	input  logic [25:0] i_vector_base,
	input  psr_word_u   i_psr,
	input  psr_word_u   i_saved_psr,
	input  logic [31:0] i_fault_address,
	input  logic [31:0] i_data_fault_address,
	output logic [31:0] o_result,
	output logic [31:0] o_op2,
	output logic        o_carry,
	output logic        o_overflow,
	output logic        o_negative,
	output logic        o_zero
);

	logic [31:0] op1;
	logic [31:0] op2;
	logic [32:0] wide;
	logic [31:0] cr_value;

	assign op1 = i_alu_op1_ra ? i_ra : i_alu_op1_rb ? i_rb : i_pc_plus_4;
	assign op2 = i_alu_op2_rb ? i_rb : i_imm32;

	assign o_op2 = op2;
	assign o_zero = (op1 ^ op2) == 32'b0;

	// Control register read path for GCR.
	always_comb begin
		case (i_cr_sel)
		`CR_VECTOR:     cr_value = {i_vector_base, 6'b0};
		`CR_PSR:        cr_value = i_psr.word;
		`CR_SAVED_PSR:  cr_value = i_saved_psr.word;
		`CR_FAULT:      cr_value = i_fault_address;
		`CR_DATA_FAULT: cr_value = i_data_fault_address;
		default:        cr_value = 32'b0;
		endcase
	end

	always_comb begin
		wide = 33'b0;
		o_overflow = 1'b0;
		o_negative = 1'b0;

		case (i_alu_opc)
		`ALU_OPC_ADD:   wide = {1'b0, op1} + {1'b0, op2};
		`ALU_OPC_ADDC:  wide = {1'b0, op1} + {1'b0, op2} + {32'b0, i_c_flag};
		`ALU_OPC_SUB:   wide = {1'b0, op1} - {1'b0, op2};
		`ALU_OPC_SUBC:  wide = {1'b0, op1} - {1'b0, op2} - {32'b0, i_c_flag};
		`ALU_OPC_LSL:   wide = {1'b0, op1} << op2[4:0];
		`ALU_OPC_LSR:   wide = {1'b0, op1 >> op2[4:0]};
		`ALU_OPC_AND:   wide = {1'b0, op1 & op2};
		`ALU_OPC_XOR:   wide = {1'b0, op1 ^ op2};
		`ALU_OPC_BIC:   wide = {1'b0, op1 & ~(32'd1 << op2[4:0])};
		`ALU_OPC_BST:   wide = {1'b0, op1 | (32'd1 << op2[4:0])};
		`ALU_OPC_OR:    wide = {1'b0, op1 | op2};
		`ALU_OPC_COPYB: wide = {1'b0, op2};
		`ALU_OPC_CMP: begin
			wide = {1'b0, op1} - {1'b0, op2};
			// Signed overflow when the operand signs differ and the
			// result sign matches the subtrahend.
			o_overflow = (op1[31] ^ op2[31]) && (wide[31] == op2[31]);
			o_negative = wide[31];
		end
		`ALU_OPC_MOVHI: wide = {1'b0, op1 | {16'b0, op2[15:0]}};
		`ALU_OPC_ASR:   wide = {1'b0, $signed(op1) >>> op2[4:0]};
		`ALU_OPC_COPYA: wide = {1'b0, op1};
		`ALU_OPC_GCR:   wide = {1'b0, cr_value};
		`ALU_OPC_SWI:   wide = {1'b0, i_vector_base, 6'h8};
		`ALU_OPC_RFE:   wide = {1'b0, i_fault_address};
		default:        wide = 33'b0;
		endcase
	end

	assign o_result = wide[31:0];

	// Bit 32 only carries meaning for add, subtract and left shift.
	always_comb begin
		case (i_alu_opc)
		`ALU_OPC_ADD, `ALU_OPC_ADDC, `ALU_OPC_SUB, `ALU_OPC_SUBC,
		`ALU_OPC_LSL, `ALU_OPC_CMP:
			o_carry = wide[32];
		default:
			o_carry = 1'b0;
		endcase
	end

	// Decode must never select ra and rb for operand one at once.
	op1_select_onehot: assert final (!(i_alu_op1_ra && i_alu_op1_rb))
		else $error("exec_alu: both operand one selects high");

endmodule

/* rtl/exec_ctrl_regs.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_ctrl_regs
	import exec_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] i_ra,
	input  logic [31:0] i_pc_plus_4,
	input  logic [31:0] i_mar,
	input  logic [2:0]  i_cr_sel,
	input  logic        i_write_cr,
	input  logic        i_update_flags,
	input  logic        i_update_carry,
	input  logic        i_alu_carry,
	input  logic        i_alu_overflow,
	input  logic        i_alu_negative,
	input  logic        i_alu_zero,
	input  logic        i_is_swi,
	input  logic        i_is_rfe,
	input  logic        i_data_abort,
	input  logic        i_exception_start,
	input  logic [2:0]  i_branch_condition,
	output logic        o_c_flag,
	output psr_word_u   o_psr,
	output psr_word_u   o_saved_psr,
	output logic [25:0] o_vector_base,
	output logic [31:0] o_fault_address,
	output logic [31:0] o_data_fault_address,
	output logic        o_condition_met
);

	logic        n_flag;
	logic        o_flag;
	logic        c_flag;
	logic        z_flag;
	logic [3:0]  saved_flags;
	logic [25:0] vector_addr;
	logic [31:0] fault_address;
	logic [31:0] data_fault_address;
	psr_word_u   ra_psr;

	// The written word is viewed as a status word for CR1 writes.
	assign ra_psr = i_ra;

	always_ff @(posedge clk) begin
		if (rst) begin
			n_flag <= 1'b0;
			o_flag <= 1'b0;
			c_flag <= 1'b0;
			z_flag <= 1'b0;
		end else if (i_write_cr && i_cr_sel == `CR_PSR) begin
			n_flag <= ra_psr.flags.n;
			o_flag <= ra_psr.flags.o;
			c_flag <= ra_psr.flags.c;
			z_flag <= ra_psr.flags.z;
		end else if (i_is_rfe) begin
			{n_flag, o_flag, c_flag, z_flag} <= saved_flags;
		end else begin
			if (i_update_flags) begin
				z_flag <= i_alu_zero;
				n_flag <= i_alu_negative;
				o_flag <= i_alu_overflow;
			end
			if (i_update_carry)
				c_flag <= i_alu_carry;
		end
	end

	// CR0 holds the exception vector base.
	always_ff @(posedge clk) begin
		if (rst)
			vector_addr <= 26'b0;
		else if (i_write_cr && i_cr_sel == `CR_VECTOR)
			vector_addr <= i_ra[31:6];
	end

	// CR2 holds the flags from before the last exception.
	always_ff @(posedge clk) begin
		if (rst)
			saved_flags <= 4'b0;
		else if (i_is_swi || i_exception_start)
			saved_flags <= {n_flag, o_flag, c_flag, z_flag};
		else if (i_write_cr && i_cr_sel == `CR_SAVED_PSR)
			saved_flags <= i_ra[3:0];
	end

	// CR3 records the return address.
	always_ff @(posedge clk) begin
		if (rst)
			fault_address <= 32'b0;
		else if (i_is_swi || i_data_abort)
			fault_address <= i_pc_plus_4;
		else if (i_write_cr && i_cr_sel == `CR_FAULT)
			fault_address <= i_ra;
	end

	// CR4 takes the address of the access that faulted.
	always_ff @(posedge clk) begin
		if (rst)
			data_fault_address <= 32'b0;
		else if (i_data_abort)
			data_fault_address <= i_mar;
		else if (i_write_cr && i_cr_sel == `CR_DATA_FAULT)
			data_fault_address <= i_ra;
	end

	always_comb begin
		o_psr.word = 32'b0;
		o_psr.flags.n = n_flag;
		o_psr.flags.o = o_flag;
		o_psr.flags.c = c_flag;
		o_psr.flags.z = z_flag;
	end

	assign o_saved_psr.word = {28'b0, saved_flags};
	assign o_c_flag = c_flag;
	assign o_vector_base = vector_addr;
	assign o_fault_address = fault_address;
	assign o_data_fault_address = data_fault_address;

	always_comb begin
		case (i_branch_condition)
		`BR_ALWAYS: o_condition_met = 1'b1;
		`BR_NE:     o_condition_met = !z_flag;
		`BR_EQ:     o_condition_met = z_flag;
		`BR_NC:     o_condition_met = !c_flag;
		`BR_C:      o_condition_met = c_flag;
		`BR_GT:     o_condition_met = !z_flag && (n_flag == o_flag);
		`BR_LT:     o_condition_met = n_flag != o_flag;
		default:    o_condition_met = 1'b0;
		endcase
	end

	// A return from exception restores CR1, so it cannot share a cycle
	// with a control register write.
	no_write_during_rfe: assert property (@(posedge clk) disable iff (rst)
		!(i_write_cr && i_is_rfe))
		else $error("exec_ctrl_regs: control register write during RFE");

endmodule

/* rtl/exec_result_regs.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_result_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] i_alu_result,
	input  logic [31:0] i_op2,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_pc_plus_4,
	input  logic [3:0]  i_rd_sel,
	input  logic        i_update_rd,
	input  logic        i_is_call,
	input  logic        i_mem_load,
	input  logic        i_mem_store,
	input  logic [1:0]  i_mem_width,
	input  logic [1:0]  i_instr_class,
	input  logic        i_condition_met,
	input  logic        i_is_swi,
	input  logic        i_is_rfe,
	output logic [31:0] o_alu_out,
	output logic [31:0] o_wr_val,
	output logic [31:0] o_mar,
	output logic [31:0] o_mdr,
	output logic [31:0] o_pc_plus_4_out,
	output logic [3:0]  o_rd_sel_out,
	output logic        o_wr_result,
	output logic        o_mem_load_out,
	output logic        o_mem_store_out,
	output logic        o_mem_wr_en,
	output logic [1:0]  o_mem_width_out,
	output logic        o_branch_taken,
	output logic        o_stall_clear
);

	logic is_branch;

	assign is_branch = i_instr_class == `CLASS_BRANCH;

	always_ff @(posedge clk) begin
		o_alu_out <= i_alu_result;
		o_rd_sel_out <= i_rd_sel;
		o_pc_plus_4_out <= i_pc_plus_4;
		o_wr_val <= i_is_call ? i_pc_plus_4 : i_mem_store ? i_op2 : i_alu_result;

		// Memory payload holds its value between accesses.
		if (i_mem_load || i_mem_store) begin
			o_mar <= i_alu_result;
			o_mem_width_out <= i_mem_width;
			if (i_mem_store)
				o_mdr <= i_rb;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_wr_result <= 1'b0;
			o_mem_load_out <= 1'b0;
			o_mem_store_out <= 1'b0;
			o_mem_wr_en <= 1'b0;
			o_branch_taken <= 1'b0;
			o_stall_clear <= 1'b0;
		end else begin
			o_wr_result <= i_update_rd;
			o_mem_load_out <= i_mem_load;
			o_mem_store_out <= i_mem_store;
			o_mem_wr_en <= i_mem_store;
			o_branch_taken <= (is_branch && i_condition_met) || i_is_swi || i_is_rfe;
			o_stall_clear <= is_branch;
		end
	end

	load_store_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(i_mem_load && i_mem_store))
		else $error("exec_result_regs: load and store in the same cycle");

endmodule

/* rtl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
	import exec_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] i_ra,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_imm32,
	input  logic [31:0] i_pc_plus_4,
	input  logic [3:0]  i_rd_sel,
	input  logic        i_update_rd,
	input  logic [4:0]  i_alu_opc,
	input  logic        i_alu_op1_ra,
	input  logic        i_alu_op1_rb,
	input  logic        i_alu_op2_rb,
	input  logic        i_mem_load,
	input  logic        i_mem_store,
	input  logic [1:0]  i_mem_width,
	input  logic [2:0]  i_branch_condition,
	input  logic [1:0]  i_instr_class,
	input  logic        i_is_call,
	input  logic        i_update_carry,
	input  logic        i_update_flags,
	input  logic [2:0]  i_cr_sel,
	input  logic        i_write_cr,
	input  logic        i_is_swi,
	input  logic        i_is_rfe,
	input  logic        i_data_abort,
	input  logic        i_exception_start,
	output logic [31:0] o_alu_out,
	output logic [31:0] o_wr_val,
	output logic [31:0] o_mar,
	output logic [31:0] o_mdr,
	output logic [31:0] o_pc_plus_4_out,
	output logic [3:0]  o_rd_sel_out,
	output logic        o_wr_result,
	output logic        o_mem_load_out,
	output logic        o_mem_store_out,
	output logic        o_mem_wr_en,
	output logic [1:0]  o_mem_width_out,
	output logic        o_branch_taken,
	output logic        o_stall_clear,
	output logic [25:0] o_vector_base
);

	logic [31:0] alu_result;
	logic [31:0] alu_op2;
	logic        alu_carry;
	logic        alu_overflow;
	logic        alu_negative;
	logic        alu_zero;
	logic        c_flag;
	psr_word_u   psr;
	psr_word_u   saved_psr;
	logic [31:0] fault_address;
	logic [31:0] data_fault_address;
	logic        condition_met;

	exec_alu i_exec_alu (
		.i_ra                 (i_ra),
		.i_rb                 (i_rb),
		.i_imm32              (i_imm32),
		.i_pc_plus_4          (i_pc_plus_4),
		.i_alu_opc            (i_alu_opc),
		.i_alu_op1_ra         (i_alu_op1_ra),
		.i_alu_op1_rb         (i_alu_op1_rb),
		.i_alu_op2_rb         (i_alu_op2_rb),
		.i_c_flag             (c_flag),
		.i_cr_sel             (i_cr_sel),
		.i_vector_base        (o_vector_base),
		.i_psr                (psr),
		.i_saved_psr          (saved_psr),
		.i_fault_address      (fault_address),
		.i_data_fault_address (data_fault_address),
		.o_result             (alu_result),
		.o_op2                (alu_op2),
		.o_carry              (alu_carry),
		.o_overflow           (alu_overflow),
		.o_negative           (alu_negative),
		.o_zero               (alu_zero)
	);

	// The registered o_mar feeds back so that a data abort captures the
	// address of the access in flight.
	exec_ctrl_regs i_exec_ctrl_regs (
		.clk                  (clk),
		.rst                  (rst),
		.i_ra                 (i_ra),
		.i_pc_plus_4          (i_pc_plus_4),
		.i_mar                (o_mar),
		.i_cr_sel             (i_cr_sel),
		.i_write_cr           (i_write_cr),
		.i_update_flags       (i_update_flags),
		.i_update_carry       (i_update_carry),
		.i_alu_carry          (alu_carry),
		.i_alu_overflow       (alu_overflow),
		.i_alu_negative       (alu_negative),
		.i_alu_zero           (alu_zero),
		.i_is_swi             (i_is_swi),
		.i_is_rfe             (i_is_rfe),
		.i_data_abort         (i_data_abort),
		.i_exception_start    (i_exception_start),
		.i_branch_condition   (i_branch_condition),
		.o_c_flag             (c_flag),
		.o_psr                (psr),
		.o_saved_psr          (saved_psr),
		.o_vector_base        (o_vector_base),
		.o_fault_address      (fault_address),
		.o_data_fault_address (data_fault_address),
		.o_condition_met      (condition_met)
	);

	exec_result_regs i_exec_result_regs (
		.clk             (clk),
		.rst             (rst),
		.i_alu_result    (alu_result),
		.i_op2           (alu_op2),
		.i_rb            (i_rb),
		.i_pc_plus_4     (i_pc_plus_4),
		.i_rd_sel        (i_rd_sel),
		.i_update_rd     (i_update_rd),
		.i_is_call       (i_is_call),
		.i_mem_load      (i_mem_load),
		.i_mem_store     (i_mem_store),
		.i_mem_width     (i_mem_width),
		.i_instr_class   (i_instr_class),
		.i_condition_met (condition_met),
		.i_is_swi        (i_is_swi),
		.i_is_rfe        (i_is_rfe),
		.o_alu_out       (o_alu_out),
		.o_wr_val        (o_wr_val),
		.o_mar           (o_mar),
		.o_mdr           (o_mdr),
		.o_pc_plus_4_out (o_pc_plus_4_out),
		.o_rd_sel_out    (o_rd_sel_out),
		.o_wr_result     (o_wr_result),
		.o_mem_load_out  (o_mem_load_out),
		.o_mem_store_out (o_mem_store_out),
		.o_mem_wr_en     (o_mem_wr_en),
		.o_mem_width_out (o_mem_width_out),
		.o_branch_taken  (o_branch_taken),
		.o_stall_clear   (o_stall_clear)
	);

endmodule

/* tb/tb_exec_stage.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_stage
	import exec_pkg::*;
();

	localparam int CYCLE_LIMIT = 2000;

	logic        clk;
	logic        rst;
	logic [31:0] i_ra;
	logic [31:0] i_rb;
	logic [31:0] i_imm32;
	logic [31:0] i_pc_plus_4;
	logic [3:0]  i_rd_sel;
	logic        i_update_rd;
	logic [4:0]  i_alu_opc;
	logic        i_alu_op1_ra;
	logic        i_alu_op1_rb;
	logic        i_alu_op2_rb;
	logic        i_mem_load;
	logic        i_mem_store;
	logic [1:0]  i_mem_width;
	logic [2:0]  i_branch_condition;
	logic [1:0]  i_instr_class;
	logic        i_is_call;
	logic        i_update_carry;
	logic        i_update_flags;
	logic [2:0]  i_cr_sel;
	logic        i_write_cr;
	logic        i_is_swi;
	logic        i_is_rfe;
	logic        i_data_abort;
	logic        i_exception_start;
	logic [31:0] o_alu_out;
	logic [31:0] o_wr_val;
	logic [31:0] o_mar;
	logic [31:0] o_mdr;
	logic [31:0] o_pc_plus_4_out;
	logic [3:0]  o_rd_sel_out;
	logic        o_wr_result;
	logic        o_mem_load_out;
	logic        o_mem_store_out;
	logic        o_mem_wr_en;
	logic [1:0]  o_mem_width_out;
	logic        o_branch_taken;
	logic        o_stall_clear;
	logic [25:0] o_vector_base;

	// Architectural state of the reference model.
	psr_word_u   m_psr;
	logic [3:0]  m_saved;
	logic [25:0] m_vector;
	logic [31:0] m_fault;
	logic [31:0] m_data_fault;

	logic [31:0] m_op1;
	logic [31:0] m_op2;
	logic [4:0]  m_sh;
	logic [63:0] m_wide;
	logic [63:0] m_sub;
	longint      m_diff;
	logic [31:0] m_result;
	logic        m_carry;
	logic        m_ovf;
	logic        m_neg;
	logic        m_zero;
	logic        m_cond;

	logic [31:0] exp_alu_out;
	logic [31:0] exp_wr_val;
	logic [31:0] exp_mar;
	logic [31:0] exp_mdr;
	logic [31:0] exp_pc_plus_4;
	logic [3:0]  exp_rd_sel;
	logic [1:0]  exp_width;
	logic        exp_wr_result;
	logic        exp_load;
	logic        exp_store;
	logic        exp_wr_en;
	logic        exp_branch;
	logic        exp_stall;
	logic        check_en = 1'b0;
	logic        started = 1'b0;
	logic        mem_seen = 1'b0;
	logic        store_seen = 1'b0;
	int          cycle_count = 0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	exec_stage i_exec_stage (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		abort_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, want));
	endtask

	task automatic idle_inputs();
		{i_ra, i_rb, i_imm32, i_pc_plus_4} = '0;
		{i_rd_sel, i_update_rd, i_alu_opc, i_alu_op1_ra, i_alu_op1_rb, i_alu_op2_rb} = '0;
		{i_mem_load, i_mem_store, i_mem_width, i_branch_condition, i_instr_class} = '0;
		{i_is_call, i_update_carry, i_update_flags, i_cr_sel, i_write_cr} = '0;
		{i_is_swi, i_is_rfe, i_data_abort, i_exception_start} = '0;
	endtask

	task automatic select_operands(input int op1_sel, input logic op2_rb);
		i_alu_op1_ra = op1_sel == 0;
		i_alu_op1_rb = op1_sel == 1;
		i_alu_op2_rb = op2_rb;
	endtask

	// Starts a new instruction slot with fresh operands and all controls idle.
	task automatic next_instruction();
		@(posedge clk);
		#1;
		idle_inputs();
		i_ra = $urandom();
		i_rb = $urandom();
		i_imm32 = $urandom();
		i_pc_plus_4 = $urandom() & 32'hffff_fffc;
	endtask

	always_comb begin
		if (i_alu_op1_ra)
			m_op1 = i_ra;
		else if (i_alu_op1_rb)
			m_op1 = i_rb;
		else
			m_op1 = i_pc_plus_4;
		m_op2 = i_alu_op2_rb ? i_rb : i_imm32;
		m_sh = m_op2[4:0];
		m_zero = m_op1 == m_op2;
		m_carry = 1'b0;
		m_ovf = 1'b0;
		m_neg = 1'b0;
		m_wide = '0;
		m_sub = '0;
		m_diff = 0;
		m_result = 32'b0;
		case (i_alu_opc)
		`ALU_OPC_ADD, `ALU_OPC_ADDC: begin
			m_wide = 64'(m_op1) + 64'(m_op2);
			if (i_alu_opc == `ALU_OPC_ADDC)
				m_wide = m_wide + 64'(m_psr.flags.c);
			m_result = m_wide[31:0];
			m_carry = m_wide[32];
		end
		`ALU_OPC_SUB, `ALU_OPC_SUBC, `ALU_OPC_CMP: begin
			// Carry is the borrow of the unsigned subtraction.
			m_sub = 64'(m_op2);
			if (i_alu_opc == `ALU_OPC_SUBC)
				m_sub = m_sub + 64'(m_psr.flags.c);
			m_result = m_op1 - m_sub[31:0];
			m_carry = 64'(m_op1) < m_sub;
			if (i_alu_opc == `ALU_OPC_CMP) begin
				m_diff = longint'($signed(m_op1)) - longint'($signed(m_op2));
				m_ovf = m_diff != longint'($signed(m_result));
				m_neg = m_result[31];
			end
		end
		`ALU_OPC_LSL: begin
			m_wide = 64'(m_op1) << m_sh;
			m_result = m_wide[31:0];
			m_carry = m_wide[32];
		end
		`ALU_OPC_LSR:   m_result = m_op1 >> m_sh;
		`ALU_OPC_AND:   m_result = m_op1 & m_op2;
		`ALU_OPC_XOR:   m_result = m_op1 ^ m_op2;
		`ALU_OPC_OR:    m_result = m_op1 | m_op2;
		`ALU_OPC_BIC: begin
			m_result = m_op1;
			m_result[m_sh] = 1'b0;
		end
		`ALU_OPC_BST: begin
			m_result = m_op1;
			m_result[m_sh] = 1'b1;
		end
		`ALU_OPC_COPYB: m_result = m_op2;
		`ALU_OPC_COPYA: m_result = m_op1;
		`ALU_OPC_MOVHI: m_result = {m_op1[31:16], m_op1[15:0] | m_op2[15:0]};
		`ALU_OPC_ASR:   m_result = 32'($signed(m_op1) >>> m_sh);
		`ALU_OPC_GCR: begin
			case (i_cr_sel)
			`CR_VECTOR:     m_result = {m_vector, 6'b0};
			`CR_PSR:        m_result = m_psr.word;
			`CR_SAVED_PSR:  m_result = {28'b0, m_saved};
			`CR_FAULT:      m_result = m_fault;
			`CR_DATA_FAULT: m_result = m_data_fault;
			default:        m_result = 32'b0;
			endcase
		end
		`ALU_OPC_SWI:   m_result = {m_vector, 6'b0} + 32'd8;
		`ALU_OPC_RFE:   m_result = m_fault;
		default:        m_result = 32'b0;
		endcase

		case (i_branch_condition)
		`BR_NE:     m_cond = !m_psr.flags.z;
		`BR_EQ:     m_cond = m_psr.flags.z;
		`BR_NC:     m_cond = !m_psr.flags.c;
		`BR_C:      m_cond = m_psr.flags.c;
		`BR_GT:     m_cond = !m_psr.flags.z && m_psr.flags.n == m_psr.flags.o;
		`BR_LT:     m_cond = m_psr.flags.n != m_psr.flags.o;
		`BR_ALWAYS: m_cond = 1'b1;
		default:    m_cond = 1'b0;
		endcase
	end

	always @(posedge clk) begin
		if (rst) begin
			m_psr.word <= 32'b0;
			m_saved <= 4'b0;
			m_vector <= 26'b0;
			m_fault <= 32'b0;
			m_data_fault <= 32'b0;
		end else begin
			if (i_write_cr && i_cr_sel == `CR_PSR) begin
				m_psr.word <= {28'b0, i_ra[3:0]};
			end else if (i_is_rfe) begin
				m_psr.word <= {28'b0, m_saved};
			end else begin
				if (i_update_flags) begin
					m_psr.flags.n <= m_neg;
					m_psr.flags.o <= m_ovf;
					m_psr.flags.z <= m_zero;
				end
				if (i_update_carry)
					m_psr.flags.c <= m_carry;
			end
			if (i_is_swi || i_exception_start)
				m_saved <= m_psr.word[3:0];
			else if (i_write_cr && i_cr_sel == `CR_SAVED_PSR)
				m_saved <= i_ra[3:0];
			if (i_write_cr && i_cr_sel == `CR_VECTOR)
				m_vector <= i_ra[31:6];
			if (i_is_swi || i_data_abort)
				m_fault <= i_pc_plus_4;
			else if (i_write_cr && i_cr_sel == `CR_FAULT)
				m_fault <= i_ra;
			// The address of the access in flight is the last registered one.
			if (i_data_abort)
				m_data_fault <= exp_mar;
			else if (i_write_cr && i_cr_sel == `CR_DATA_FAULT)
				m_data_fault <= i_ra;
		end
	end

	always @(posedge clk) begin
		check_en <= !rst;
		started <= 1'b1;
		exp_alu_out <= m_result;
		exp_wr_val <= i_is_call ? i_pc_plus_4 : (i_mem_store ? m_op2 : m_result);
		exp_pc_plus_4 <= i_pc_plus_4;
		exp_rd_sel <= i_rd_sel;
		if (i_mem_load || i_mem_store) begin
			mem_seen <= 1'b1;
			exp_mar <= m_result;
			exp_width <= i_mem_width;
		end
		if (i_mem_store) begin
			store_seen <= 1'b1;
			exp_mdr <= i_rb;
		end
		if (rst) begin
			{exp_wr_result, exp_load, exp_store, exp_wr_en, exp_branch, exp_stall} <= '0;
		end else begin
			exp_wr_result <= i_update_rd;
			exp_load <= i_mem_load;
			exp_store <= i_mem_store;
			exp_wr_en <= i_mem_store;
			exp_branch <= (i_instr_class == `CLASS_BRANCH && m_cond) || i_is_swi || i_is_rfe;
			exp_stall <= i_instr_class == `CLASS_BRANCH;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			abort_run("Timeout: the run went past its cycle limit without finishing.");
	end

	alu_out_check: assert property (@(posedge clk) !check_en || o_alu_out == exp_alu_out)
		else report_mismatch("o_alu_out", $sampled(o_alu_out), $sampled(exp_alu_out));
	wr_val_check: assert property (@(posedge clk) !check_en || o_wr_val == exp_wr_val)
		else report_mismatch("o_wr_val", $sampled(o_wr_val), $sampled(exp_wr_val));
	pc_check: assert property (@(posedge clk) !check_en || o_pc_plus_4_out == exp_pc_plus_4)
		else report_mismatch("o_pc_plus_4_out", $sampled(o_pc_plus_4_out),
			$sampled(exp_pc_plus_4));
	rd_sel_check: assert property (@(posedge clk) !check_en || o_rd_sel_out == exp_rd_sel)
		else report_mismatch("o_rd_sel_out", $sampled(o_rd_sel_out), $sampled(exp_rd_sel));
	mar_check: assert property (@(posedge clk) !mem_seen || o_mar == exp_mar)
		else report_mismatch("o_mar", $sampled(o_mar), $sampled(exp_mar));
	width_check: assert property (@(posedge clk) !mem_seen || o_mem_width_out == exp_width)
		else report_mismatch("o_mem_width_out", $sampled(o_mem_width_out), $sampled(exp_width));
	mdr_check: assert property (@(posedge clk) !store_seen || o_mdr == exp_mdr)
		else report_mismatch("o_mdr", $sampled(o_mdr), $sampled(exp_mdr));
	wr_result_check: assert property (@(posedge clk) !started || o_wr_result == exp_wr_result)
		else report_mismatch("o_wr_result", $sampled(o_wr_result), $sampled(exp_wr_result));
	load_check: assert property (@(posedge clk) !started || o_mem_load_out == exp_load)
		else report_mismatch("o_mem_load_out", $sampled(o_mem_load_out), $sampled(exp_load));
	store_check: assert property (@(posedge clk) !started || o_mem_store_out == exp_store)
		else report_mismatch("o_mem_store_out", $sampled(o_mem_store_out), $sampled(exp_store));
	wr_en_check: assert property (@(posedge clk) !started || o_mem_wr_en == exp_wr_en)
		else report_mismatch("o_mem_wr_en", $sampled(o_mem_wr_en), $sampled(exp_wr_en));
	branch_check: assert property (@(posedge clk) !started || o_branch_taken == exp_branch)
		else report_mismatch("o_branch_taken", $sampled(o_branch_taken), $sampled(exp_branch));
	stall_check: assert property (@(posedge clk) !started || o_stall_clear == exp_stall)
		else report_mismatch("o_stall_clear", $sampled(o_stall_clear), $sampled(exp_stall));
	vector_check: assert property (@(posedge clk) !started || o_vector_base == m_vector)
		else report_mismatch("o_vector_base", $sampled(o_vector_base), $sampled(m_vector));

	initial begin
		int pick;

		void'($urandom(32'hc621_ae75));
		rst = 1'b1;
		idle_inputs();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Every computing opcode against every operand selection.
		for (int round = 0; round < 2; round++)
			for (int opc = `ALU_OPC_ADD; opc <= `ALU_OPC_COPYA; opc++)
				for (int sel = 0; sel < 6; sel++) begin
					next_instruction();
					i_alu_opc = 5'(opc);
					select_operands(sel / 2, 1'(sel % 2));
					i_update_carry = 1'b1;
					i_update_flags = 1'($urandom());
					i_update_rd = 1'b1;
					i_rd_sel = 4'($urandom());
				end

		// Compare, then branch on each condition.
		for (int round = 0; round < 4; round++)
			for (int cond = 0; cond < 8; cond++) begin
				next_instruction();
				i_alu_opc = `ALU_OPC_CMP;
				select_operands(0, 1'b1);
				if ($urandom_range(0, 1) == 0)
					i_rb = i_ra;
				i_update_flags = 1'b1;
				i_update_carry = 1'b1;
				next_instruction();
				i_instr_class = `CLASS_BRANCH;
				i_branch_condition = 3'(cond);
				i_is_call = 1'($urandom());
				i_update_rd = i_is_call;
			end

		// Control register writes and GCR read back.
		for (int round = 0; round < 4; round++) begin
			for (int cr = 0; cr < 5; cr++) begin
				next_instruction();
				i_write_cr = 1'b1;
				i_cr_sel = 3'(cr);
				next_instruction();
				i_alu_opc = `ALU_OPC_GCR;
				i_cr_sel = 3'(cr);
			end
			for (int cr = 0; cr < 8; cr++) begin
				next_instruction();
				i_alu_opc = `ALU_OPC_GCR;
				i_cr_sel = 3'(cr);
			end
		end

		// Software interrupt and return from exception.
		for (int round = 0; round < 8; round++) begin
			next_instruction();
			i_write_cr = 1'b1;
			i_cr_sel = `CR_PSR;
			next_instruction();
			i_alu_opc = `ALU_OPC_SWI;
			i_is_swi = 1'b1;
			i_instr_class = `CLASS_MISC;
			next_instruction();
			i_alu_opc = `ALU_OPC_CMP;
			select_operands(0, 1'b1);
			i_update_flags = 1'b1;
			i_update_carry = 1'b1;
			next_instruction();
			i_alu_opc = `ALU_OPC_RFE;
			i_is_rfe = 1'b1;
			next_instruction();
			i_exception_start = 1'b1;
			next_instruction();
			i_alu_opc = `ALU_OPC_GCR;
			i_cr_sel = `CR_SAVED_PSR;
		end

		// Loads, stores and data aborts.
		for (int round = 0; round < 16; round++) begin
			next_instruction();
			select_operands(0, 1'b0);
			pick = $urandom_range(0, 1);
			i_mem_load = pick == 0;
			i_mem_store = pick == 1;
			i_mem_width = 2'($urandom());
			i_instr_class = `CLASS_LDR_STR;
			i_update_rd = i_mem_load;
			next_instruction();
			i_data_abort = 1'b1;
			next_instruction();
			i_alu_opc = `ALU_OPC_GCR;
			i_cr_sel = `CR_DATA_FAULT;
			next_instruction();
			i_alu_opc = `ALU_OPC_GCR;
			i_cr_sel = `CR_FAULT;
		end

		// Mixed random traffic within the decode rules.
		for (int n = 0; n < 400; n++) begin
			next_instruction();
			i_alu_opc = 5'($urandom_range(0, 18));
			select_operands($urandom_range(0, 2), 1'($urandom()));
			if ($urandom_range(0, 3) == 0)
				i_rb = i_ra;
			i_rd_sel = 4'($urandom());
			i_update_rd = 1'($urandom());
			i_is_call = $urandom_range(0, 3) == 0;
			pick = $urandom_range(0, 3);
			i_mem_load = pick == 1;
			i_mem_store = pick == 2;
			i_mem_width = 2'($urandom());
			i_instr_class = 2'($urandom());
			i_branch_condition = 3'($urandom());
			i_update_flags = 1'($urandom());
			i_update_carry = 1'($urandom());
			i_cr_sel = 3'($urandom());
			i_is_swi = $urandom_range(0, 15) == 0;
			i_is_rfe = $urandom_range(0, 15) == 0;
			i_data_abort = $urandom_range(0, 15) == 0;
			i_exception_start = $urandom_range(0, 15) == 0;
			i_write_cr = !i_is_rfe && $urandom_range(0, 7) == 0;
		end

		next_instruction();
		repeat (3) @(posedge clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/exec_ctrl_regs.sv
rtl/exec_result_regs.sv
rtl/exec_stage.sv
tb/tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/exec_pkg.sv
      - rtl/exec_alu.sv
      - rtl/exec_ctrl_regs.sv
      - rtl/exec_result_regs.sv
      - rtl/exec_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_exec_stage.sv
